//--- hdl/coeff_packer.sv
`timescale 1ns/1ps
`default_nettype none

module coeff_packer #(
  parameter int WORDS_PER_BURST = imager_pkg::WORDS_PER_BURST
) (
  input  wire                          bus_clk,
  input  wire                          fds_val,
  input  wire                          coeff_valid,
  input  wire imager_pkg::coeff_word_t coeff,
  input  wire                          burst_ack,
  output logic                         coeff_ready,
  output logic                         burst_req,
  output imager_pkg::burst_t           burst
);

  import imager_pkg::*;

  localparam int BUF_W = 2 * APP_DATA_WIDTH;
  localparam int WORD_W = BUF_W / WORDS_PER_BURST;
  localparam int OFF_W = $clog2(WORDS_PER_BURST);

  logic [BUF_W-1:0] words;  // word 0 in the low bits
  logic [OFF_W-1:0] offset;
  logic             last_q;
  logic             closing;

  assign closing = coeff.last || (offset == OFF_W'(WORDS_PER_BURST - 1));

  assign coeff_ready = !burst_req;
  assign burst.beat0 = app_data_t'(words[APP_DATA_WIDTH-1:0]);
  assign burst.beat1 = app_data_t'(words[BUF_W-1:APP_DATA_WIDTH]);
  assign burst.last  = last_q;

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      offset    <= '0;
      burst_req <= 1'b0;
      last_q    <= 1'b0;
    end else if (burst_req) begin
      if (burst_ack) burst_req <= 1'b0;  // writer has both beats
    end else if (coeff_valid) begin
      offset <= closing ? '0 : offset + 1'b1;
      if (closing) begin
        burst_req <= 1'b1;
        last_q    <= coeff.last;
      end
    end
  end

  // first word of a burst zero-fills the rest, so an early last pads with 0
  always_ff @(posedge bus_clk) begin
    if (coeff_valid && !burst_req) begin
      if (offset == '0) words <= BUF_W'(coeff.data[WORD_W-1:0]);
      else words[offset*WORD_W +: WORD_W] <= coeff.data[WORD_W-1:0];
    end
  end

  // router only strobes a word while a slot is free
  a_valid_when_ready: assert property (
    @(posedge bus_clk) disable iff (fds_val)
    coeff_valid |-> coeff_ready
  ) else $error("coeff_valid while coeff_ready low");

endmodule

`default_nettype wire

//--- hdl/dram_burst_writer.sv
`timescale 1ns/1ps
`default_nettype none

module dram_burst_writer #(
  parameter imager_pkg::addr_t START_ADDR = imager_pkg::START_ADDR,
  parameter imager_pkg::addr_t ADDR_INC   = imager_pkg::ADDR_INC
) (
  input  wire                     bus_clk,
  input  wire                     fds_val,
  input  wire                     burst_req,
  input  wire imager_pkg::burst_t burst,
  input  wire                     app_rdy,
  input  wire                     app_wdf_rdy,
  output logic                    burst_ack,
  output logic                    app_en,
  output imager_pkg::addr_t       app_addr,
  output logic                    app_wdf_wren,
  output imager_pkg::app_data_t   app_wdf_data,
  output logic                    app_wdf_end,
  output logic                    coeff_done
);

  import imager_pkg::*;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_WAIT,
    WR1,
    WR2,
    DONE_ACK
  } wr_state_e;

  wr_state_e state;
  addr_t     next_addr;

  assign next_addr = app_addr + ADDR_INC;

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state        <= WR_IDLE;
      burst_ack    <= 1'b0;
      app_en       <= 1'b0;
      app_addr     <= START_ADDR;
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b0;
      coeff_done   <= 1'b0;
    end else begin
      case (state)
        WR_IDLE:
          if (burst_req && !burst_ack) begin
            if (coeff_done) begin
              burst_ack <= 1'b1;  // table closed, drop it
              state     <= DONE_ACK;
            end else begin
              app_en <= 1'b1;
              state  <= WR_WAIT;
            end
          end
        WR_WAIT:
          if (app_rdy && app_wdf_rdy) begin
            app_en       <= 1'b0;  // command taken
            app_wdf_wren <= 1'b1;
            state        <= WR1;
          end
        WR1:
          if (app_wdf_rdy) begin  // beat0 accepted
            app_wdf_end <= 1'b1;
            state       <= WR2;
          end
        WR2:
          if (app_wdf_rdy) begin
            app_wdf_wren <= 1'b0;
            app_wdf_end  <= 1'b0;
            app_addr     <= next_addr;
            burst_ack    <= 1'b1;
            if (burst.last) coeff_done <= 1'b1;
            state <= DONE_ACK;
          end
        DONE_ACK:
          if (!burst_req) begin
            burst_ack <= 1'b0;
            state     <= WR_IDLE;
          end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // write data path, burst held stable by the packer until ack
  always_ff @(posedge bus_clk) begin
    if (state == WR_WAIT && app_rdy && app_wdf_rdy) app_wdf_data <= burst.beat0;
    else if (state == WR1 && app_wdf_rdy) app_wdf_data <= burst.beat1;
  end

  a_end_with_wren: assert property (
    @(posedge bus_clk) disable iff (fds_val)
    app_wdf_end |-> app_wdf_wren
  ) else $error("app_wdf_end without app_wdf_wren");

endmodule

`default_nettype wire

//--- hdl/frame_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module frame_tracker #(
  parameter int PIXELS_PER_CLK = imager_pkg::PIXELS_PER_CLK
) (
  input  wire                           bus_clk,
  input  wire                           fds_val,
  input  wire                           pixel_valid,
  input  wire imager_pkg::pixel_sample_t pixel,
  output imager_pkg::pixel_pos_t        pos,
  output logic                          line_active,
  output logic                          error
);

  import imager_pkg::*;

  // 2k rows plus 8 dark rows top and bottom
  localparam row_t ROW_MAX  = row_t'(2064);
  localparam col_t COL_STEP = col_t'(PIXELS_PER_CLK);

  typedef enum logic [2:0] {
    ST_STANDBY,
    ST_INTERFRAME,
    ST_INTRALINE,
    ST_INTERLINE,
    ST_ERROR
  } trk_state_e;

  trk_state_e state;
  logic       bad_sample;

  assign bad_sample  = pixel.lval && !pixel.fval;  // line outside a frame
  assign line_active = (state == ST_INTRALINE);
  assign error       = (state == ST_ERROR);

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state <= ST_STANDBY;
      pos   <= '0;
    end else if (pixel_valid) begin
      if (bad_sample) begin
        state <= ST_ERROR;
      end else begin
        case (state)
          ST_STANDBY:
            if (!pixel.fval) begin  // wait for a frame gap to sync
              pos   <= '0;
              state <= ST_INTERFRAME;
            end
          ST_INTERFRAME:
            if (pixel.lval) begin
              pos.row <= '0;
              pos.col <= '0;
              state   <= ST_INTRALINE;
            end
          ST_INTRALINE:
            if (pixel.lval) begin
              pos.col <= pos.col + COL_STEP;
            end else if (pixel.fval) begin
              pos.row <= pos.row + 1'b1;  // end of line
              state   <= ST_INTERLINE;
            end else begin
              pos.frame <= pos.frame + 1'b1;  // end of frame
              state     <= ST_INTERFRAME;
            end
          ST_INTERLINE:
            if (pixel.lval) begin
              pos.col <= '0;
              state   <= ST_INTRALINE;
            end
          default: begin
            // error holds until reset
          end
        endcase
      end
    end
  end

  a_row_in_range: assert property (
    @(posedge bus_clk) disable iff (fds_val)
    pos.row < ROW_MAX
  ) else $error("row count past sensor height");

endmodule

`default_nettype wire

//--- hdl/host_msg_router.sv
`timescale 1ns/1ps
`default_nettype none

module host_msg_router (
  input  wire                         bus_clk,
  input  wire                         fds_val,
  input  wire                         msg_req,
  input  wire imager_pkg::msg_t       msg_data,
  input  wire                         coeff_ready,
  output logic                        msg_ack,
  output logic                        pixel_valid,
  output imager_pkg::pixel_sample_t   pixel,
  output logic                        coeff_valid,
  output imager_pkg::coeff_word_t     coeff
);

  import imager_pkg::*;

  typedef enum logic {
    RT_IDLE,
    RT_ACK
  } rt_state_e;

  rt_state_e state;
  msg_kind_e kind;
  logic      is_coeff;
  logic      take;

  assign kind     = msg_kind_e'(msg_data[1:0]);
  assign is_coeff = (kind == MSG_COEFF) || (kind == MSG_COEFF_LAST);

  // hold off coefficients while the packer has a burst pending
  assign take = msg_req && (state == RT_IDLE) && (!is_coeff || coeff_ready);

  assign msg_ack = (state == RT_ACK);

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state       <= RT_IDLE;
      pixel_valid <= 1'b0;
      coeff_valid <= 1'b0;
    end else begin
      pixel_valid <= take && (kind == MSG_PIXEL);
      coeff_valid <= take && is_coeff;  // reserved kinds get no strobe
      case (state)
        RT_IDLE: if (take) state <= RT_ACK;
        RT_ACK:  if (!msg_req) state <= RT_IDLE;  // phase 4
        default: state <= RT_IDLE;
      endcase
    end
  end

  // decoded payloads, valid alongside their strobes
  always_ff @(posedge bus_clk) begin
    if (take) begin
      pixel.fval <= msg_data[5];
      pixel.lval <= msg_data[4];
      coeff.data <= coeff_data_t'(msg_data[MSG_WIDTH-1:2]);
      coeff.last <= (kind == MSG_COEFF_LAST);
    end
  end

  // ack only answers a request seen on the previous edge
  a_ack_needs_req: assert property (
    @(posedge bus_clk) disable iff (fds_val)
    $rose(msg_ack) |-> $past(msg_req)
  ) else $error("msg_ack rose without msg_req");

endmodule

`default_nettype wire

//--- hdl/imager_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module imager_frontend #(
  parameter int                WORDS_PER_BURST = imager_pkg::WORDS_PER_BURST,
  parameter int                PIXELS_PER_CLK  = imager_pkg::PIXELS_PER_CLK,
  parameter imager_pkg::addr_t START_ADDR      = imager_pkg::START_ADDR,
  parameter imager_pkg::addr_t ADDR_INC        = imager_pkg::ADDR_INC
) (
  input  wire                   bus_clk,
  input  wire                   fds_val,
  input  wire                   msg_req,
  input  wire imager_pkg::msg_t msg_data,
  input  wire                   app_rdy,
  input  wire                   app_wdf_rdy,
  output logic                  msg_ack,
  output imager_pkg::pixel_pos_t pos,
  output logic                  line_active,
  output logic                  error,
  output logic                  app_en,
  output imager_pkg::addr_t     app_addr,
  output logic                  app_wdf_wren,
  output imager_pkg::app_data_t app_wdf_data,
  output logic                  app_wdf_end,
  output logic                  coeff_done
);

  import imager_pkg::*;

  logic          pixel_valid;
  pixel_sample_t pixel;
  logic          coeff_valid;
  coeff_word_t   coeff;
  logic          coeff_ready;
  logic          burst_req;
  logic          burst_ack;
  burst_t        burst;

  host_msg_router u_host_msg_router (
    .bus_clk, .fds_val, .msg_req, .msg_data, .coeff_ready,
    .msg_ack, .pixel_valid, .pixel, .coeff_valid, .coeff
  );

  frame_tracker #(.PIXELS_PER_CLK(PIXELS_PER_CLK)) u_frame_tracker (
    .bus_clk, .fds_val, .pixel_valid, .pixel,
    .pos, .line_active, .error
  );

  coeff_packer #(.WORDS_PER_BURST(WORDS_PER_BURST)) u_coeff_packer (
    .bus_clk, .fds_val, .coeff_valid, .coeff, .burst_ack,
    .coeff_ready, .burst_req, .burst
  );

  dram_burst_writer #(
    .START_ADDR(START_ADDR),
    .ADDR_INC  (ADDR_INC)
  ) u_dram_burst_writer (
    .bus_clk, .fds_val, .burst_req, .burst, .app_rdy, .app_wdf_rdy,
    .burst_ack, .app_en, .app_addr, .app_wdf_wren, .app_wdf_data,
    .app_wdf_end, .coeff_done
  );

endmodule

`default_nettype wire

//--- hdl/imager_pkg.sv
`default_nettype none

package imager_pkg;

  localparam int MSG_WIDTH       = 16;
  localparam int APP_DATA_WIDTH  = 32;
  localparam int ADDR_WIDTH      = 27;
  localparam int WORDS_PER_BURST = 4;  // two beats of two words
  localparam int PIXELS_PER_CLK  = 2;

  typedef logic [MSG_WIDTH-1:0]        msg_t;
  typedef logic [APP_DATA_WIDTH-1:0]   app_data_t;
  typedef logic [ADDR_WIDTH-1:0]       addr_t;
  typedef logic [APP_DATA_WIDTH/2-1:0] coeff_data_t;  // half a beat
  typedef logic [11:0]                 row_t;
  typedef logic [10:0]                 col_t;
  typedef logic [19:0]                 frame_t;

  localparam addr_t START_ADDR = addr_t'(0);
  localparam addr_t ADDR_INC   = addr_t'(8);  // BL8

  // message kind sits in the two low bits
  typedef enum logic [1:0] {
    MSG_PIXEL      = 2'b00,
    MSG_COEFF_LAST = 2'b01,
    MSG_COEFF      = 2'b10,
    MSG_RESERVED   = 2'b11
  } msg_kind_e;

  typedef struct packed {
    logic fval;  // msg bit 5
    logic lval;  // msg bit 4
  } pixel_sample_t;

  typedef struct packed {
    coeff_data_t data;
    logic        last;
  } coeff_word_t;

  typedef struct packed {
    frame_t frame;
    row_t   row;
    col_t   col;
  } pixel_pos_t;

  typedef struct packed {
    app_data_t beat0;  // words 1,0
    app_data_t beat1;  // words 3,2
    logic      last;
  } burst_t;

endpackage

`default_nettype wire

//--- imager_frontend.f
hdl/imager_pkg.sv
hdl/host_msg_router.sv
hdl/frame_tracker.sv
hdl/coeff_packer.sv
hdl/dram_burst_writer.sv
hdl/imager_frontend.sv
testbench/tb_imager_frontend.sv

//--- run_sim.sh
#!/bin/sh
# build and run the imager front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_imager_frontend -f imager_frontend.f -o sim_imager
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_imager)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

//--- testbench/imager_stimulus.txt
// op msg col row frame flags; op 1 send and check tracker, 2 send, 3 drain DRAM,
// 4 end of test (msg = test id), 5 reset, 0 end; flags bit0 line_active, bit1 error, bit2 coeff_done
// test 1: handshakes, standby pixels and reserved kinds
1 0020 0 0 0 0
1 0003 0 0 0 0
1 0020 0 0 0 0
1 00ff 0 0 0 0
1 0013 0 0 0 0
4 1 0 0 0 0
// test 2: two frames of three lines
1 0000 0 0 0 1
1 0030 0 0 0 1
1 0030 2 0 0 1
1 0020 2 1 0 0
1 0030 0 1 0 1
1 0020 0 2 0 0
1 0030 0 2 0 1
1 0000 0 2 1 0
1 0030 0 0 1 1
1 0020 0 1 1 0
1 0030 0 1 1 1
1 0030 2 1 1 1
1 0020 2 2 1 0
1 0030 0 2 1 1
1 0000 0 2 2 0
4 2 0 0 0 0
// test 3: line outside a frame, error sticks
1 0010 0 2 2 2
1 0030 0 2 2 2
1 0020 0 2 2 2
4 3 0 0 0 0
5 0 0 0 0 0
// test 4: eight words, two bursts
2 048e 0 0 0 0
2 115a 0 0 0 0
2 1e26 0 0 0 0
2 2af2 0 0 0 0
2 77be 0 0 0 0
2 8006 0 0 0 0
2 fffe 0 0 0 0
2 000a 0 0 0 0
3 0 0 0 0 0
4 4 0 0 0 0
// test 5: short last burst with pixels in between
1 0000 0 0 0 0
2 48d2 0 0 0 0
1 0030 0 0 0 1
2 2b3a 0 0 0 0
1 0030 2 0 0 1
2 f169 0 0 0 0
1 0030 4 0 0 1
1 0020 4 1 0 0
3 0 0 0 0 4
4 5 0 0 0 0
0 0 0 0 0 0

//--- testbench/tb_imager_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_imager_frontend;

  import imager_pkg::*;

  localparam int MAX_OPS    = 96;
  localparam int COLS       = 6;   // op, msg, col, row, frame, flags
  localparam int RST_CYCLES = 16;
  localparam int OP_CYCLES  = 40;

  // tracker model states
  localparam int TRK_STANDBY    = 0;
  localparam int TRK_INTERFRAME = 1;
  localparam int TRK_INTRALINE  = 2;
  localparam int TRK_INTERLINE  = 3;
  localparam int TRK_ERROR      = 4;

  logic       bus_clk;
  logic       fds_val;
  logic       msg_req;
  msg_t       msg_data;
  logic       app_rdy = 1'b0;
  logic       app_wdf_rdy = 1'b0;
  logic       msg_ack;
  pixel_pos_t pos;
  logic       line_active;
  logic       error;
  logic       app_en;
  addr_t      app_addr;
  logic       app_wdf_wren;
  app_data_t  app_wdf_data;
  logic       app_wdf_end;
  logic       coeff_done;

  logic [19:0] stim [0:MAX_OPS*COLS-1];
  int          n_ops;
  int          cycle_limit = 0;
  int          cycles = 0;
  int          chk_errors = 0;
  int          mon_errors = 0;

  // packing model with words landing low first
  logic [15:0] word_buf [0:3];
  int          word_cnt;
  app_data_t   exp_beat0 [0:7];
  app_data_t   exp_beat1 [0:7];
  int          exp_count;
  int          trk_state;

  int          ack_count = 0;
  int          bursts_done = 0;
  int          beat_idx = 0;
  logic        prev_req = 1'b0;
  logic        prev_ack = 1'b0;
  logic        cmd_seen = 1'b0;
  addr_t       cmd_addr = '0;
  logic [31:0] lfsr = 32'h822;
  logic [3:0]  stall_bits;

  imager_frontend u_imager_frontend (
    .bus_clk, .fds_val, .msg_req, .msg_data, .app_rdy, .app_wdf_rdy,
    .msg_ack, .pos, .line_active, .error, .app_en, .app_addr,
    .app_wdf_wren, .app_wdf_data, .app_wdf_end, .coeff_done
  );

  initial begin
    bus_clk = 1'b0;
    forever #10 bus_clk = ~bus_clk;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int errs);
    assert (got === exp) else begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errs++;
    end
  endtask

  task automatic expect_true(input string what, input logic ok, inout int errs);
    assert (ok) else begin
      $display("error: %s", what);
      errs++;
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic clear_words();
    for (int k = 0; k < 4; k++) word_buf[k] = 16'h0;
    word_cnt = 0;
  endtask

  task automatic clear_model();
    clear_words();
    exp_count = 0;
    trk_state = TRK_STANDBY;
  endtask

  task automatic apply_reset();
    repeat (RST_CYCLES) @(posedge bus_clk);
    fds_val <= 1'b0;
  endtask

  // four-phase host handshake
  task automatic send_msg(input msg_t m);
    int acks_before;
    acks_before = ack_count;
    @(posedge bus_clk);
    msg_data <= m;
    msg_req  <= 1'b1;
    @(posedge bus_clk);
    while (!msg_ack) @(posedge bus_clk);
    msg_req <= 1'b0;
    @(posedge bus_clk);
    while (msg_ack) @(posedge bus_clk);
    compare_value("msg_ack count", 32'(ack_count - acks_before), 32'd1, chk_errors);
  endtask

  task automatic model_coeff(input msg_t m);
    msg_kind_e kind;
    kind = msg_kind_e'(m[1:0]);
    if (kind == MSG_COEFF || kind == MSG_COEFF_LAST) begin
      word_buf[word_cnt] = {2'b00, m[15:2]};
      word_cnt++;
      if (word_cnt == WORDS_PER_BURST || kind == MSG_COEFF_LAST) begin
        exp_beat0[exp_count] = {word_buf[1], word_buf[0]};
        exp_beat1[exp_count] = {word_buf[3], word_buf[2]};  // unfilled slots stay 0
        exp_count++;
        clear_words();
      end
    end
  endtask

  // frame timing states that decide line_active
  task automatic model_pixel(input msg_t m);
    logic fv;
    logic lv;
    fv = m[5];
    lv = m[4];
    if (msg_kind_e'(m[1:0]) == MSG_PIXEL) begin
      if (lv && !fv) begin
        trk_state = TRK_ERROR;
      end else begin
        case (trk_state)
          TRK_STANDBY:
            if (!fv) trk_state = TRK_INTERFRAME;
          TRK_INTERFRAME:
            if (lv) trk_state = TRK_INTRALINE;
          TRK_INTRALINE:
            if (!lv) trk_state = fv ? TRK_INTERLINE : TRK_INTERFRAME;
          TRK_INTERLINE:
            if (lv) trk_state = TRK_INTRALINE;
          default: begin
            // error holds until reset
          end
        endcase
      end
    end
  endtask

  task automatic verify_position(input int base);
    compare_value("pos.col", 32'(pos.col), 32'(stim[base+2]), chk_errors);
    compare_value("pos.row", 32'(pos.row), 32'(stim[base+3]), chk_errors);
    compare_value("pos.frame", 32'(pos.frame), 32'(stim[base+4]), chk_errors);
    compare_value("line_active", 32'(line_active), 32'(trk_state == TRK_INTRALINE),
                  chk_errors);
    compare_value("error", 32'(error), 32'(stim[base+5][1]), chk_errors);
  endtask

  task automatic wait_drained(input int base);
    while (bursts_done != exp_count) @(posedge bus_clk);
    compare_value("coeff_done", 32'(coeff_done), 32'(stim[base+5][2]), chk_errors);
  endtask

  // random DRAM back-pressure with each line ready 3 cycles in 4
  always @(posedge bus_clk) begin
    for (int k = 0; k < 4; k++) begin
      lfsr = lfsr_step(lfsr);
      stall_bits[k] = lfsr[0];
    end
    app_rdy     <= stall_bits[0] | stall_bits[1];
    app_wdf_rdy <= stall_bits[2] | stall_bits[3];
  end

  // handshake order and DRAM write monitor
  always @(posedge bus_clk) begin
    prev_req <= msg_req;
    prev_ack <= msg_ack;
    if (msg_ack && !prev_ack) begin
      ack_count <= ack_count + 1;
      expect_true("msg_ack rose without a pending msg_req", prev_req, mon_errors);
    end
    if (!msg_ack && prev_ack)
      expect_true("msg_ack dropped while msg_req was still high", !prev_req, mon_errors);
    if (fds_val) begin
      beat_idx    <= 0;
      cmd_seen    <= 1'b0;
      bursts_done <= 0;
    end else begin
      if (app_en && app_rdy && !cmd_seen) begin
        cmd_seen <= 1'b1;
        cmd_addr <= app_addr;
      end
      if (app_wdf_wren && app_wdf_rdy) begin
        if (beat_idx == 0) begin
          compare_value("app_wdf_data", app_wdf_data, exp_beat0[bursts_done & 7], mon_errors);
          compare_value("app_wdf_end", 32'(app_wdf_end), 32'd0, mon_errors);
          beat_idx <= 1;
        end else begin
          expect_true("DRAM burst written with none expected", bursts_done < exp_count,
                      mon_errors);
          expect_true("second beat written before any DRAM command", cmd_seen, mon_errors);
          compare_value("app_wdf_data", app_wdf_data, exp_beat1[bursts_done & 7], mon_errors);
          compare_value("app_wdf_end", 32'(app_wdf_end), 32'd1, mon_errors);
          compare_value("app_addr", 32'(cmd_addr),
                        32'(START_ADDR) + 32'(bursts_done) * 32'(ADDR_INC), mon_errors);
          beat_idx    <= 0;
          cmd_seen    <= 1'b0;
          bursts_done <= bursts_done + 1;
        end
      end
    end
  end

  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    int   i;
    int   op;
    int   base;
    int   tests_run;
    int   tests_failed;
    int   errs_at_start;
    msg_t m;
    fds_val  <= 1'b1;
    msg_req  <= 1'b0;
    msg_data <= '0;
    tests_run     = 0;
    tests_failed  = 0;
    errs_at_start = 0;
    clear_model();
    $readmemh("testbench/imager_stimulus.txt", stim);
    n_ops = 0;
    while (n_ops < MAX_OPS && stim[n_ops*COLS] != 20'd0) n_ops++;
    cycle_limit = n_ops * OP_CYCLES + RST_CYCLES;
    apply_reset();
    for (i = 0; i < n_ops; i++) begin
      base = i * COLS;
      op   = int'(stim[base]);
      m    = msg_t'(stim[base+1]);
      case (op)
        1, 2: begin
          send_msg(m);
          model_coeff(m);
          model_pixel(m);
          if (op == 1) verify_position(base);
        end
        3: wait_drained(base);
        4: begin
          tests_run++;
          if (chk_errors + mon_errors == errs_at_start) begin
            $display("test %0d ok", int'(m));
          end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", int'(m),
                     chk_errors + mon_errors - errs_at_start);
          end
          errs_at_start = chk_errors + mon_errors;
        end
        5: begin  // fresh start as the tracker error is sticky
          @(posedge bus_clk);
          fds_val <= 1'b1;
          apply_reset();
          clear_model();
        end
        default: expect_true("unknown opcode in stimulus file", 1'b0, chk_errors);
      endcase
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             chk_errors + mon_errors);
    if (tests_failed == 0 && chk_errors + mon_errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
